//--- Bender.yml
package:
  name: uno_table

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/uno_pkg.sv
      - hdl/card_dealer.sv
      - hdl/deal_fifo.sv
      - hdl/move_rules.sv
      - hdl/turn_sequencer.sv
      - hdl/uno_table.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - tests/uno_table_checker.sv
      - tests/tb_uno_table.sv

//--- hdl/card_dealer.sv
`include "uno_settings.svh"

module card_dealer (
    input  logic           i_clk,
    input  logic           i_rst_n,
    input  logic           i_req,
    output logic           o_valid,
    output uno_pkg::card_t o_card,
    input  logic           i_ready
);
    import uno_pkg::*;

    logic [15:0] lfsr_r, lfsr_w;
    logic        valid_r, valid_w;
    card_t       card_r, card_w;
    card_t       offer;
    logic        stall;
    logic        step;

    assign stall  = valid_r && !i_ready;   // card held until the FIFO takes it
    assign step   = i_req && !stall;
    assign offer  = lfsr_r[5:0];
    assign lfsr_w = {1'b0, lfsr_r[15:1]} ^ (lfsr_r[0] ? 16'hB400 : 16'h0000);

    always_comb begin
        valid_w = valid_r;
        card_w  = card_r;
        if (!stall) begin
            valid_w = step && (card_face(offer) != FACE_NONE);   // drop face 15
            card_w  = offer;
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            lfsr_r  <= `UNO_LFSR_SEED;
            valid_r <= 1'b0;
        end
        else begin
            if (step) begin
                lfsr_r <= lfsr_w;
            end
            valid_r <= valid_w;
        end
    end

    always_ff @(posedge i_clk) begin
        card_r <= card_w;
    end

    assign o_valid = valid_r;
    assign o_card  = card_r;

endmodule

//--- hdl/deal_fifo.sv
`include "uno_settings.svh"

module deal_fifo (
    input  logic           i_clk,
    input  logic           i_rst_n,
    input  logic           i_push,
    input  uno_pkg::card_t i_card,
    output logic           o_full,
    output logic           o_valid,
    output uno_pkg::card_t o_card,
    input  logic           i_pop
);
    import uno_pkg::*;

    localparam int DEPTH = `UNO_FIFO_DEPTH;
    localparam int AW    = $clog2(DEPTH);
    localparam int CW    = $clog2(DEPTH + 1);

    card_t         mem [DEPTH];
    logic [AW-1:0] wr_ptr_r, rd_ptr_r;
    logic [CW-1:0] count_r;
    logic          push_ok, pop_ok;

    function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] ptr);
        return (ptr == AW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign o_full  = (count_r == CW'(DEPTH));
    assign o_valid = (count_r != '0);
    assign o_card  = mem[rd_ptr_r];   // head of queue
    assign push_ok = i_push && !o_full;
    assign pop_ok  = i_pop && o_valid;

    always_ff @(posedge i_clk) begin
        if (push_ok) begin
            mem[wr_ptr_r] <= i_card;
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            wr_ptr_r <= '0;
            rd_ptr_r <= '0;
            count_r  <= '0;
        end
        else begin
            if (push_ok) wr_ptr_r <= ptr_inc(wr_ptr_r);
            if (pop_ok)  rd_ptr_r <= ptr_inc(rd_ptr_r);
            case ({push_ok, pop_ok})
                2'b10:   count_r <= count_r + 1'b1;
                2'b01:   count_r <= count_r - 1'b1;
                default: count_r <= count_r;   // both or neither
            endcase
        end
    end

endmodule

//--- hdl/move_rules.sv
module move_rules (
    input  uno_pkg::seat_t i_seat,
    input  logic           i_reversed,
    input  uno_pkg::move_t i_move,
    output uno_pkg::seat_t o_next_seat,
    output logic           o_reversed,
    output uno_pkg::seat_t o_victim,
    output logic [2:0]     o_penalty
);
    import uno_pkg::*;

    face_t face;
    logic  play;
    logic  flip;
    seat_t one_step;
    seat_t two_step;

    assign face = card_face(i_move.card);
    assign play = !i_move.draw;
    assign flip = play && (face == FACE_REVERSE);

    // reverse steps in the new direction, so use the updated flag
    assign o_reversed = i_reversed ^ flip;

    // 2-bit seat wraps modulo 4
    assign one_step = o_reversed ? i_seat - 2'd1 : i_seat + 2'd1;
    assign two_step = o_reversed ? i_seat - 2'd2 : i_seat + 2'd2;

    always_comb begin
        o_next_seat = one_step;
        o_victim    = one_step;
        o_penalty   = 3'd0;
        if (i_move.draw) begin
            o_victim  = i_seat;   // mover takes the card
            o_penalty = 3'd1;
        end
        else begin
            case (face)
                FACE_SKIP: begin
                    o_next_seat = two_step;
                end
                FACE_DRAW2: begin
                    o_next_seat = two_step;   // victim loses the turn
                    o_penalty   = 3'd2;
                end
                FACE_WILD4: begin
                    o_next_seat = two_step;
                    o_penalty   = 3'd4;
                end
                default: begin
                    o_next_seat = one_step;
                end
            endcase
        end
    end

endmodule

//--- hdl/turn_sequencer.sv
`include "uno_settings.svh"

module turn_sequencer (
    input  logic             i_clk,
    input  logic             i_rst_n,
    input  logic             i_start,
    input  logic             i_wb_cyc,
    input  logic             i_wb_stb,
    input  logic             i_wb_we,
    input  uno_pkg::move_t   i_wb_dat,
    output logic             o_wb_ack,
    output uno_pkg::status_t o_wb_dat,
    output logic             o_req,
    input  logic             i_fifo_valid,
    input  uno_pkg::card_t   i_fifo_card,
    output logic             o_pop,
    output logic             o_card_valid,
    output uno_pkg::dealt_t  o_card,
    output uno_pkg::card_t   o_top_card
);
    import uno_pkg::*;

    localparam int DEAL_CARDS = `UNO_SEATS * `UNO_HAND_SIZE;
    localparam int NEED_W     = $clog2(DEAL_CARDS + 1);
    localparam int HAND_W     = $clog2(`UNO_HAND_SIZE);

    phase_e            phase_r, phase_w;
    seat_t             seat_r, seat_w;
    logic              reversed_r, reversed_w;
    card_t             top_r, top_w;
    logic [NEED_W-1:0] need_r, need_w;   // cards still to send out
    seat_t             recv_r, recv_w;
    logic [HAND_W-1:0] hand_cnt_r, hand_cnt_w;
    logic              ack_r;
    logic              card_valid_r;
    dealt_t            card_r;
    logic              wb_req;
    logic              wr_accept;
    seat_t             rule_next;
    seat_t             rule_victim;
    logic              rule_reversed;
    logic [2:0]        rule_penalty;

    move_rules rules0 (
        .i_seat      (seat_r),
        .i_reversed  (reversed_r),
        .i_move      (i_wb_dat),
        .o_next_seat (rule_next),
        .o_reversed  (rule_reversed),
        .o_victim    (rule_victim),
        .o_penalty   (rule_penalty)
    );

    // no new request while ack is out so ack lasts one cycle
    assign wb_req    = i_wb_cyc && i_wb_stb && !ack_r;
    assign wr_accept = wb_req && i_wb_we && (phase_r == PH_PLAY);

    // need is nonzero only while dealing or in a penalty
    assign o_req = (need_r != '0);
    assign o_pop = i_fifo_valid && (need_r != '0);

    always_comb begin
        phase_w    = phase_r;
        seat_w     = seat_r;
        reversed_w = reversed_r;
        top_w      = top_r;
        need_w     = need_r;
        recv_w     = recv_r;
        hand_cnt_w = hand_cnt_r;
        case (phase_r)
            PH_IDLE: begin
                if (i_start) begin
                    phase_w    = PH_DEAL;
                    need_w     = NEED_W'(DEAL_CARDS);
                    recv_w     = '0;
                    hand_cnt_w = '0;
                end
            end
            PH_DEAL: begin
                if (o_pop) begin
                    need_w = need_r - 1'b1;
                    if (hand_cnt_r == HAND_W'(`UNO_HAND_SIZE - 1)) begin
                        hand_cnt_w = '0;
                        recv_w     = recv_r + 2'd1;   // next seat's hand
                    end
                    else begin
                        hand_cnt_w = hand_cnt_r + 1'b1;
                    end
                    if (need_r == NEED_W'(1)) begin
                        phase_w = PH_PLAY;
                    end
                end
            end
            PH_PLAY: begin
                if (wr_accept) begin
                    seat_w     = rule_next;
                    reversed_w = rule_reversed;
                    if (!i_wb_dat.draw) begin
                        top_w = i_wb_dat.card;
                    end
                    if (rule_penalty != 3'd0) begin
                        need_w  = NEED_W'(rule_penalty);
                        recv_w  = rule_victim;
                        phase_w = PH_PENALTY;
                    end
                end
            end
            PH_PENALTY: begin
                if (o_pop) begin
                    need_w = need_r - 1'b1;
                    if (need_r == NEED_W'(1)) begin
                        phase_w = PH_PLAY;   // turn already moved at the ack
                    end
                end
            end
            default: begin
                phase_w = PH_IDLE;
            end
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            phase_r      <= PH_IDLE;
            seat_r       <= '0;
            reversed_r   <= 1'b0;
            top_r        <= '0;
            need_r       <= '0;
            recv_r       <= '0;
            hand_cnt_r   <= '0;
            ack_r        <= 1'b0;
            card_valid_r <= 1'b0;
        end
        else begin
            phase_r      <= phase_w;
            seat_r       <= seat_w;
            reversed_r   <= reversed_w;
            top_r        <= top_w;
            need_r       <= need_w;
            recv_r       <= recv_w;
            hand_cnt_r   <= hand_cnt_w;
            ack_r        <= wb_req && (!i_wb_we || phase_r == PH_PLAY);   // writes stall
            card_valid_r <= o_pop;
        end
    end

    always_ff @(posedge i_clk) begin
        if (o_pop) begin
            card_r.seat <= recv_r;
            card_r.card <= i_fifo_card;
        end
    end

    assign o_wb_ack     = ack_r;
    assign o_wb_dat     = '{seat: seat_r, reversed: reversed_r, phase: phase_r};
    assign o_card_valid = card_valid_r;
    assign o_card       = card_r;
    assign o_top_card   = top_r;

endmodule

//--- hdl/uno_pkg.sv
package uno_pkg;

    typedef logic [1:0] color_t;
    typedef logic [3:0] face_t;
    typedef logic [5:0] card_t;   // {color, face}
    typedef logic [1:0] seat_t;   // seat 0 gets the first hand and moves first

    // 0..9 are number cards
    localparam face_t FACE_SKIP    = 4'd10;
    localparam face_t FACE_REVERSE = 4'd11;
    localparam face_t FACE_DRAW2   = 4'd12;
    localparam face_t FACE_WILD    = 4'd13;
    localparam face_t FACE_WILD4   = 4'd14;
    localparam face_t FACE_NONE    = 4'd15;   // never a legal card

    typedef struct packed {
        logic  draw;   // set to take one card instead of playing
        card_t card;
    } move_t;

    typedef struct packed {
        seat_t seat;   // receiving seat
        card_t card;
    } dealt_t;

    typedef enum logic [1:0] {
        PH_IDLE,
        PH_DEAL,
        PH_PLAY,
        PH_PENALTY
    } phase_e;

    typedef struct packed {
        seat_t  seat;
        logic   reversed;
        phase_e phase;
    } status_t;

    function automatic face_t card_face(input card_t card);
        return card[3:0];
    endfunction

endpackage

//--- hdl/uno_settings.svh
`ifndef UNO_SETTINGS_SVH
`define UNO_SETTINGS_SVH

// table size
`define UNO_SEATS      4
`define UNO_HAND_SIZE  7   // cards per seat at the deal

// deal FIFO entries
`define UNO_FIFO_DEPTH 4

// must be nonzero
`define UNO_LFSR_SEED  16'hACE1

`endif

//--- hdl/uno_table.sv
module uno_table (
    input  logic             i_clk,
    input  logic             i_rst_n,
    input  logic             i_start,
    input  logic             i_wb_cyc,
    input  logic             i_wb_stb,
    input  logic             i_wb_we,
    input  uno_pkg::move_t   i_wb_dat,
    output logic             o_wb_ack,
    output uno_pkg::status_t o_wb_dat,
    output logic             o_card_valid,
    output uno_pkg::dealt_t  o_card,
    output uno_pkg::card_t   o_top_card
);
    import uno_pkg::*;

    logic  dealer_valid;
    card_t dealer_card;
    logic  fifo_full;
    logic  fifo_valid;
    card_t fifo_card;
    logic  fifo_pop;
    logic  seq_req;

    card_dealer dealer0 (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_req   (seq_req),
        .o_valid (dealer_valid),
        .o_card  (dealer_card),
        .i_ready (!fifo_full)
    );

    deal_fifo fifo0 (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_push  (dealer_valid),
        .i_card  (dealer_card),
        .o_full  (fifo_full),
        .o_valid (fifo_valid),
        .o_card  (fifo_card),
        .i_pop   (fifo_pop)
    );

    turn_sequencer seq0 (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_start      (i_start),
        .i_wb_cyc     (i_wb_cyc),
        .i_wb_stb     (i_wb_stb),
        .i_wb_we      (i_wb_we),
        .i_wb_dat     (i_wb_dat),
        .o_wb_ack     (o_wb_ack),
        .o_wb_dat     (o_wb_dat),
        .o_req        (seq_req),
        .i_fifo_valid (fifo_valid),
        .i_fifo_card  (fifo_card),
        .o_pop        (fifo_pop),
        .o_card_valid (o_card_valid),
        .o_card       (o_card),
        .o_top_card   (o_top_card)
    );

endmodule

//--- project.f
+incdir+hdl
hdl/uno_pkg.sv
hdl/card_dealer.sv
hdl/deal_fifo.sv
hdl/move_rules.sv
hdl/turn_sequencer.sv
hdl/uno_table.sv
tests/uno_table_checker.sv
tests/tb_uno_table.sv

//--- tests/tb_uno_table.sv
`include "uno_settings.svh"

module tb_uno_table;
    import uno_pkg::*;

    localparam int NUM_TESTS  = 5;
    localparam int HAND       = `UNO_HAND_SIZE;
    localparam int DEAL_CARDS = `UNO_SEATS * `UNO_HAND_SIZE;

    logic    i_clk;
    logic    i_rst_n;
    logic    i_start;
    logic    i_wb_cyc;
    logic    i_wb_stb;
    logic    i_wb_we;
    move_t   i_wb_dat;
    logic    o_wb_ack;
    status_t o_wb_dat;
    logic    o_card_valid;
    dealt_t  o_card;
    card_t   o_top_card;

    integer  seed = 94469;
    int      card_total = 0;
    dealt_t  card_log [$];
    int      ref_seat = 0;
    int      ref_dir = 1;   // -1 once reversed
    card_t   ref_top = '0;

    uno_table dut0 (.*);

    always #50 i_clk = ~i_clk;

    always @(posedge i_clk) begin   // card collector
        if (i_rst_n && o_card_valid) begin
            card_log.push_back(o_card);
            card_total = card_total + 1;
        end
    end

    initial begin
        #((200 * NUM_TESTS + 500) * 100);
        $display("timeout: the tests did not finish in the expected time");
        $display("SOME TESTS FAILED");
        $fatal(1, "watchdog expired");
    end

    task automatic check_value(input int actual, input int expected, input string what);
        if (actual != expected) begin
            $display("[ERROR] %0t: %s: got %0d, expected %0d", $time, what, actual, expected);
            $display("SOME TESTS FAILED");
            $fatal(1, "mismatch");
        end
    endtask

    task automatic wb_access(input logic we, input move_t dat, output status_t status);
        @(negedge i_clk);
        i_wb_cyc = 1'b1;
        i_wb_stb = 1'b1;
        i_wb_we  = we;
        i_wb_dat = dat;
        @(negedge i_clk);
        while (!o_wb_ack) begin   // writes stall outside play
            @(negedge i_clk);
        end
        status   = o_wb_dat;
        i_wb_cyc = 1'b0;
        i_wb_stb = 1'b0;
        i_wb_we  = 1'b0;
    endtask

    task automatic wb_write(input move_t move);
        status_t unused;
        wb_access(1'b1, move, unused);
    endtask

    task automatic wb_read(output status_t status);
        wb_access(1'b0, '0, status);
    endtask

    function automatic card_t make_card(input face_t face);
        return {2'($random(seed)), face};
    endfunction

    function automatic card_t number_card();
        return make_card(4'({$random(seed)} % 10));
    endfunction

    function automatic move_t play_card(input card_t card);
        return '{draw: 1'b0, card: card};
    endfunction

    function automatic int seat_after(input int steps);
        return (ref_seat + ref_dir * steps + 8) % 4;
    endfunction

    // expected table state after a move
    task automatic apply_move(input move_t move, output int victim, output int penalty);
        victim  = ref_seat;
        penalty = 0;
        if (move.draw) begin
            penalty  = 1;
            ref_seat = seat_after(1);
        end
        else begin
            ref_top = move.card;
            case (move.card[3:0])
                FACE_SKIP: ref_seat = seat_after(2);
                FACE_REVERSE: begin
                    ref_dir  = -ref_dir;
                    ref_seat = seat_after(1);
                end
                FACE_DRAW2, FACE_WILD4: begin
                    victim   = seat_after(1);
                    penalty  = (move.card[3:0] == FACE_DRAW2) ? 2 : 4;
                    ref_seat = seat_after(2);
                end
                default: ref_seat = seat_after(1);
            endcase
        end
    endtask

    task automatic check_status(input phase_e phase, input string what);
        status_t st;
        wb_read(st);
        check_value(st.seat, ref_seat, {what, ": seat"});
        check_value(st.reversed, ref_dir < 0, {what, ": reversed"});
        check_value(st.phase, phase, {what, ": phase"});
        check_value(o_top_card, ref_top, {what, ": top card"});
    endtask

    task automatic play_move(input move_t move, input bit stall_write);
        int    base;
        int    victim;
        int    penalty;
        int    extra_victim;
        int    extra_penalty;
        move_t extra;
        base = card_total;
        wb_write(move);
        apply_move(move, victim, penalty);
        if (stall_write) begin
            extra = play_card(number_card());
            wb_write(extra);   // held off until the penalty is out
            check_value(card_total - base, penalty, "cards out when stalled write acked");
            apply_move(extra, extra_victim, extra_penalty);
        end
        wait (card_total >= base + penalty);
        for (int i = base; i < base + penalty; i++) begin
            check_value(card_log[i].seat, victim, "drawn card seat");
        end
        check_status(PH_PLAY, "after move");
        check_value(card_total - base, penalty, "drawn card count");
    endtask

    task automatic test_deal();
        status_t st;
        check_value(o_card_valid, 0, "card valid after reset");
        check_status(PH_IDLE, "after reset");
        @(negedge i_clk);
        i_start = 1'b1;
        @(negedge i_clk);
        i_start = 1'b0;
        st.phase = PH_DEAL;
        while (st.phase != PH_PLAY) begin
            wb_read(st);
        end
        check_status(PH_PLAY, "after deal");
        check_value(card_total, DEAL_CARDS, "deal card count");
        for (int i = 0; i < DEAL_CARDS; i++) begin
            check_value(card_log[i].seat, i / HAND, "deal seat order");
            check_value(card_log[i].card[3:0] != 4'hF, 1, "deal card face legal");
        end
    endtask

    task automatic test_number_wild();
        repeat (3) play_move(play_card(number_card()), 1'b0);
        play_move(play_card(make_card(FACE_WILD)), 1'b0);
    endtask

    task automatic test_skip_reverse();
        play_move(play_card(make_card(FACE_SKIP)), 1'b0);
        play_move(play_card(make_card(FACE_REVERSE)), 1'b0);
        play_move(play_card(number_card()), 1'b0);
        play_move(play_card(make_card(FACE_SKIP)), 1'b0);
        play_move(play_card(make_card(FACE_REVERSE)), 1'b0);
        play_move(play_card(number_card()), 1'b0);
    endtask

    task automatic test_draw_penalty();
        play_move(play_card(make_card(FACE_DRAW2)), 1'b1);
        play_move(play_card(make_card(FACE_WILD4)), 1'b1);
        play_move(play_card(make_card(FACE_REVERSE)), 1'b0);
        play_move(play_card(make_card(FACE_DRAW2)), 1'b0);
        play_move(play_card(make_card(FACE_WILD4)), 1'b0);
    endtask

    task automatic test_draw_move();
        play_move('{draw: 1'b1, card: number_card()}, 1'b0);
        play_move(play_card(make_card(FACE_REVERSE)), 1'b0);
        play_move('{draw: 1'b1, card: number_card()}, 1'b0);
    endtask

    initial begin
        i_clk    = 1'b0;
        i_rst_n  = 1'b0;
        i_start  = 1'b0;
        i_wb_cyc = 1'b0;
        i_wb_stb = 1'b0;
        i_wb_we  = 1'b0;
        i_wb_dat = '0;
        repeat (5) @(posedge i_clk);
        @(negedge i_clk);
        i_rst_n = 1'b1;
        test_deal();
        test_number_wild();
        test_skip_reverse();
        test_draw_penalty();
        test_draw_move();
        if (dut0.chk0.fail_count == 0) begin
            $display("ALL TESTS PASSED");
            $finish;
        end
        else begin
            $display("SOME TESTS FAILED");
            $fatal(1, "assertion failures seen");
        end
    end

endmodule

//--- tests/uno_table_checker.sv
module uno_table_checker (
    input logic            i_clk,
    input logic            i_rst_n,
    input logic            i_wb_cyc,
    input logic            i_wb_stb,
    input logic            o_wb_ack,
    input logic            o_card_valid,
    input uno_pkg::dealt_t o_card
);
    int fail_count = 0;

    card_face_legal: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_card_valid |-> (o_card.card[3:0] != 4'hF))
        else begin
            fail_count = fail_count + 1;
            $error("card stream carried face 15");
        end

    // ack answers a request seen on the previous edge
    ack_needs_request: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_wb_ack |-> $past(i_wb_cyc && i_wb_stb))
        else begin
            fail_count = fail_count + 1;
            $error("wishbone ack without cyc and stb");
        end

    ack_single_cycle: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_wb_ack |=> !o_wb_ack)
        else begin
            fail_count = fail_count + 1;
            $error("wishbone ack high for two cycles");
        end

endmodule

bind uno_table uno_table_checker chk0 (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_wb_cyc     (i_wb_cyc),
    .i_wb_stb     (i_wb_stb),
    .o_wb_ack     (o_wb_ack),
    .o_card_valid (o_card_valid),
    .o_card       (o_card)
);
